/* rtl/rv_execute_pkg.sv */
package rv_execute_pkg;

  // One operation word, read by the ALU, divider or load/store path
  typedef union packed {
    logic [3:0] alu;
    struct packed {
      logic [1:0] unused;
      logic       sign;                 // Signed operands when set
      logic       rem;                  // Remainder instead of quotient
    } div;
    struct packed {
      logic       store;
      logic       unsigned_load;        // Zero extension of loaded data
      logic [1:0] size;
    } lsu;
  } exec_op_u;

  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_and  = 4'd2;
  localparam logic [3:0] alu_or   = 4'd3;
  localparam logic [3:0] alu_xor  = 4'd4;
  localparam logic [3:0] alu_sll  = 4'd5;
  localparam logic [3:0] alu_srl  = 4'd6;
  localparam logic [3:0] alu_sra  = 4'd7;
  localparam logic [3:0] alu_slt  = 4'd8;
  localparam logic [3:0] alu_sltu = 4'd9;

  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

endpackage

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu #(
  parameter int xlen = 32
) (
  input  logic [xlen-1:0] alu_a,
  input  logic [xlen-1:0] alu_b,
  input  logic [3:0]      alu_op,
  output logic [xlen-1:0] alu_result
);

  localparam int shw = $clog2(xlen);

  logic [shw-1:0] shamt;

  assign shamt = alu_b[shw-1:0]; // Only the low bits count for shifts

  always_comb begin
    case (alu_op)
      rv_execute_pkg::alu_add: begin
        alu_result = alu_a + alu_b;
      end
      rv_execute_pkg::alu_sub: begin
        alu_result = alu_a - alu_b;
      end
      rv_execute_pkg::alu_and: begin
        alu_result = alu_a & alu_b;
      end
      rv_execute_pkg::alu_or: begin
        alu_result = alu_a | alu_b;
      end
      rv_execute_pkg::alu_xor: begin
        alu_result = alu_a ^ alu_b;
      end
      rv_execute_pkg::alu_sll: begin
        alu_result = alu_a << shamt;
      end
      rv_execute_pkg::alu_srl: begin
        alu_result = alu_a >> shamt;
      end
      rv_execute_pkg::alu_sra: begin
        alu_result = xlen'($signed(alu_a) >>> shamt);
      end
      rv_execute_pkg::alu_slt: begin
        alu_result = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      end
      rv_execute_pkg::alu_sltu: begin
        alu_result = {{(xlen-1){1'b0}}, alu_a < alu_b};
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

endmodule

/* rtl/divider.sv */
`timescale 1ns/10ps

module divider #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            div_start,
  input  logic [xlen-1:0] div_dividend,
  input  logic [xlen-1:0] div_divisor,
  input  logic            div_sign,
  input  logic            div_rem,
  output logic            div_ready,
  output logic [xlen-1:0] div_result
);

  localparam int cw = $clog2(xlen);

  logic            busy;
  logic [cw-1:0]   count;
  logic [xlen-1:0] quo;                 // Dividend bits shift out, quotient bits shift in
  logic [xlen-1:0] part;                // Partial remainder
  logic [xlen-1:0] dvsr;
  logic [xlen-1:0] dividend_q;
  logic            neg_q;
  logic            neg_r;
  logic            by_zero;
  logic            op_rem;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic [xlen:0]   trial;
  logic [xlen-1:0] q_fix;
  logic [xlen-1:0] r_fix;

  assign a_mag = (div_sign & div_dividend[xlen-1]) ? -div_dividend : div_dividend;
  assign b_mag = (div_sign & div_divisor[xlen-1]) ? -div_divisor : div_divisor;
  assign trial = {part, quo[xlen-1]} - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      busy      <= 1'b0;
      count     <= '0;
      div_ready <= 1'b0;
    end else begin
      div_ready <= 1'b0;
      if (div_start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (count == cw'(xlen - 1)) begin
          busy      <= 1'b0;
          div_ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_start) begin
      quo        <= a_mag;
      part       <= '0;
      dvsr       <= b_mag;
      dividend_q <= div_dividend;
      by_zero    <= (div_divisor == '0);
      neg_q      <= div_sign & (div_dividend[xlen-1] ^ div_divisor[xlen-1]);
      neg_r      <= div_sign & div_dividend[xlen-1];
      op_rem     <= div_rem;
    end else if (busy) begin
      quo  <= {quo[xlen-2:0], ~trial[xlen]};
      part <= trial[xlen] ? {part[xlen-2:0], quo[xlen-1]} : trial[xlen-1:0]; // Restore on borrow
    end
  end

  // Most negative over minus one wraps back to the dividend in the magnitude path
  assign q_fix = neg_q ? -quo : quo;
  assign r_fix = neg_r ? -part : part;
  assign div_result = by_zero ? (op_rem ? dividend_q : '1) : (op_rem ? r_fix : q_fix);

  // The stage must wait for the previous result before starting again
  assert property (@(posedge clk) disable iff (rst == 0) div_start |-> !busy)
    else $error("divider: start while busy");

endmodule

/* rtl/load_align.sv */
`timescale 1ns/10ps

module load_align #(
  parameter int xlen = 32
) (
  input  logic [xlen-1:0]           mem_word,
  input  logic [$clog2(xlen/8)-1:0] load_offset,
  input  logic [1:0]                load_size,
  input  logic                      load_unsigned,
  output logic [xlen-1:0]           load_data
);

  logic [xlen-1:0] shifted;

  assign shifted = mem_word >> {load_offset, 3'b000}; // Addressed byte lands at bit 0

  always_comb begin
    int   width;
    logic ext;
    case (load_size)
      rv_execute_pkg::size_byte: begin
        width = 8;
      end
      rv_execute_pkg::size_half: begin
        width = 16;
      end
      rv_execute_pkg::size_word: begin
        width = 32;
      end
      default: begin
        width = xlen;
      end
    endcase
    ext = ~load_unsigned & shifted[width-1];
    for (int i = 0; i < xlen; i++) begin
      load_data[i] = (i < width) ? shifted[i] : ext;
    end
  end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage #(
  parameter int xlen = 32
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      valid,
  input  rv_execute_pkg::exec_op_u  op,
  input  logic                      is_alu,
  input  logic                      is_lui,
  input  logic                      is_auipc,
  input  logic                      is_jump,
  input  logic                      is_div,
  input  logic                      is_load,
  input  logic                      is_store,
  input  logic                      use_imm,
  input  logic [xlen-1:0]           pc,
  input  logic [xlen-1:0]           npc,
  input  logic [xlen-1:0]           imm,
  input  logic [xlen-1:0]           address,
  input  logic [xlen-1:0]           rdata1,
  input  logic [xlen-1:0]           rdata2,
  input  logic [4:0]                waddr,
  input  logic                      clear,
  input  logic [xlen-1:0]           mem_rdata,
  input  logic                      mem_ready,
  input  logic [xlen-1:0]           alu_result,
  input  logic                      div_ready,
  input  logic [xlen-1:0]           div_result,
  input  logic [xlen-1:0]           load_data,
  output logic [xlen-1:0]           alu_a,
  output logic [xlen-1:0]           alu_b,
  output logic [3:0]                alu_op,
  output logic                      div_start,
  output logic [xlen-1:0]           div_dividend,
  output logic [xlen-1:0]           div_divisor,
  output logic                      div_sign,
  output logic                      div_rem,
  output logic [xlen-1:0]           mem_word,
  output logic [$clog2(xlen/8)-1:0] load_offset,
  output logic [1:0]                load_size,
  output logic                      load_unsigned,
  output logic                      reg_wren,
  output logic [4:0]                reg_waddr,
  output logic [xlen-1:0]           reg_wdata,
  output logic                      stall,
  output logic                      stall_q
);

  localparam int ow = $clog2(xlen / 8);
  localparam int pw = 4 + 8 + 5 * xlen + 5;

  logic [pw-1:0]            fresh_payload;
  logic [pw-1:0]            held_payload;
  logic [pw-1:0]            cur_payload;
  logic                     held_valid;
  logic                     cur_valid;
  rv_execute_pkg::exec_op_u cur_op;
  logic                     cur_is_alu, cur_is_lui, cur_is_auipc, cur_is_jump;
  logic                     cur_is_div, cur_is_load, cur_is_store, cur_use_imm;
  logic [xlen-1:0]          cur_npc, cur_imm, cur_address, cur_rdata1, cur_rdata2;
  logic [4:0]               cur_waddr;
  logic                     mem_op;
  logic                     unit_done;

  assign fresh_payload = {op, is_alu, is_lui, is_auipc, is_jump, is_div, is_load, is_store,
                          use_imm, npc, imm, address, rdata1, rdata2, waddr};

  // While stalled the stage runs from its own copy and ignores the issuer
  assign cur_payload = stall_q ? held_payload : fresh_payload;
  assign cur_valid   = stall_q ? held_valid : valid;

  assign {cur_op, cur_is_alu, cur_is_lui, cur_is_auipc, cur_is_jump, cur_is_div, cur_is_load,
          cur_is_store, cur_use_imm, cur_npc, cur_imm, cur_address, cur_rdata1,
          cur_rdata2, cur_waddr} = cur_payload;

  assign alu_a  = cur_rdata1;
  assign alu_b  = cur_use_imm ? cur_imm : cur_rdata2;
  assign alu_op = cur_op.alu;

  assign div_start    = cur_valid & cur_is_div & ~clear & ~stall_q; // First cycle only
  assign div_dividend = cur_rdata1;
  assign div_divisor  = cur_rdata2;
  assign div_sign     = cur_op.div.sign;
  assign div_rem      = cur_op.div.rem;

  assign mem_word      = mem_rdata;
  assign load_offset   = cur_address[ow-1:0];
  assign load_size     = cur_op.lsu.size;
  assign load_unsigned = cur_op.lsu.unsigned_load;

  assign mem_op    = cur_is_load | cur_is_store;
  assign stall     = cur_valid & ~clear & ((cur_is_div & ~div_ready) | (mem_op & ~mem_ready));
  assign unit_done = cur_is_alu | cur_is_lui | cur_is_auipc | cur_is_jump |
                     (cur_is_div & div_ready) | (cur_is_load & mem_ready);

  always_comb begin
    if (cur_is_auipc) begin
      reg_wdata = cur_address;
    end else if (cur_is_lui) begin
      reg_wdata = cur_imm;
    end else if (cur_is_jump) begin
      reg_wdata = cur_npc;              // Link value
    end else if (cur_is_div) begin
      reg_wdata = div_result;
    end else if (cur_is_load) begin
      reg_wdata = load_data;
    end else begin
      reg_wdata = alu_result;
    end
  end

  assign reg_waddr = cur_waddr;
  assign reg_wren  = cur_valid & ~clear & unit_done & (cur_waddr != 5'd0); // Units finish unstalled

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      held_valid <= 1'b0;
      stall_q    <= 1'b0;
    end else begin
      held_valid <= cur_valid & ~clear; // A clear flushes the held instruction too
      stall_q    <= stall;
    end
  end

  always_ff @(posedge clk) begin
    held_payload <= cur_payload;
  end

  assert property (@(posedge clk) disable iff (rst == 0) stall |-> !reg_wren)
    else $error("execute_stage: register write while stalled");

  assert property (@(posedge clk) disable iff (rst == 0) reg_wren |-> reg_waddr != 5'd0)
    else $error("execute_stage: write to register zero");

  assert property (@(posedge clk) disable iff (rst == 0) div_start |-> !$past(stall))
    else $error("execute_stage: divider started during a stall");

endmodule

/* rtl/rv_execute_top.sv */
`timescale 1ns/10ps

module rv_execute_top #(
  parameter int xlen = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     valid,
  input  rv_execute_pkg::exec_op_u op,
  input  logic                     is_alu,
  input  logic                     is_lui,
  input  logic                     is_auipc,
  input  logic                     is_jump,
  input  logic                     is_div,
  input  logic                     is_load,
  input  logic                     is_store,
  input  logic                     use_imm,
  input  logic [xlen-1:0]          pc,
  input  logic [xlen-1:0]          npc,
  input  logic [xlen-1:0]          imm,
  input  logic [xlen-1:0]          address,
  input  logic [xlen-1:0]          rdata1,
  input  logic [xlen-1:0]          rdata2,
  input  logic [4:0]               waddr,
  input  logic                     clear,
  input  logic [xlen-1:0]          mem_rdata,
  input  logic                     mem_ready,
  output logic                     reg_wren,
  output logic [4:0]               reg_waddr,
  output logic [xlen-1:0]          reg_wdata,
  output logic                     stall,
  output logic                     stall_q
);

  logic [xlen-1:0]           alu_a, alu_b, alu_result;
  logic [3:0]                alu_op;
  logic                      div_start, div_sign, div_rem, div_ready;
  logic [xlen-1:0]           div_dividend, div_divisor, div_result;
  logic [xlen-1:0]           mem_word, load_data;
  logic [$clog2(xlen/8)-1:0] load_offset;
  logic [1:0]                load_size;
  logic                      load_unsigned;

  execute_stage #(.xlen(xlen)) execute_stage_inst (
    .clk(clk), .rst(rst), .valid(valid), .op(op),
    .is_alu(is_alu), .is_lui(is_lui), .is_auipc(is_auipc), .is_jump(is_jump),
    .is_div(is_div), .is_load(is_load), .is_store(is_store), .use_imm(use_imm),
    .pc(pc), .npc(npc), .imm(imm), .address(address),
    .rdata1(rdata1), .rdata2(rdata2), .waddr(waddr), .clear(clear),
    .mem_rdata(mem_rdata), .mem_ready(mem_ready), .alu_result(alu_result),
    .div_ready(div_ready), .div_result(div_result), .load_data(load_data),
    .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .div_start(div_start),
    .div_dividend(div_dividend), .div_divisor(div_divisor),
    .div_sign(div_sign), .div_rem(div_rem), .mem_word(mem_word),
    .load_offset(load_offset), .load_size(load_size), .load_unsigned(load_unsigned),
    .reg_wren(reg_wren), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
    .stall(stall), .stall_q(stall_q)
  );

  alu #(.xlen(xlen)) alu_inst (
    .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_result(alu_result)
  );

  divider #(.xlen(xlen)) divider_inst (
    .clk(clk), .rst(rst), .div_start(div_start),
    .div_dividend(div_dividend), .div_divisor(div_divisor),
    .div_sign(div_sign), .div_rem(div_rem),
    .div_ready(div_ready), .div_result(div_result)
  );

  load_align #(.xlen(xlen)) load_align_inst (
    .mem_word(mem_word), .load_offset(load_offset), .load_size(load_size),
    .load_unsigned(load_unsigned), .load_data(load_data)
  );

endmodule

/* testbench/rv_execute_tb.sv */
`timescale 1ns/10ps

module rv_execute_tb;

  localparam int xlen = 32;
  localparam int u_alu = 0;
  localparam int u_lui = 1;
  localparam int u_auipc = 2;
  localparam int u_jump = 3;
  localparam int u_div = 4;
  localparam int u_load = 5;
  localparam int u_store = 6;

  typedef struct packed {
    int              unit;
    logic [3:0]      code;
    logic            imm_sel;
    logic            flush;
    logic [4:0]      dest;
    logic [xlen-1:0] a_val;
    logic [xlen-1:0] b_val;
    logic [xlen-1:0] imm_val;
    logic [xlen-1:0] addr_val;
    logic [xlen-1:0] mem_val;
    logic            wr;
    logic [xlen-1:0] wr_val;
  } entry_t;

  logic                     clk;
  logic                     rst;
  logic                     valid;
  rv_execute_pkg::exec_op_u op;
  logic                     is_alu;
  logic                     is_lui;
  logic                     is_auipc;
  logic                     is_jump;
  logic                     is_div;
  logic                     is_load;
  logic                     is_store;
  logic                     use_imm;
  logic [xlen-1:0]          pc;
  logic [xlen-1:0]          npc;
  logic [xlen-1:0]          imm;
  logic [xlen-1:0]          address;
  logic [xlen-1:0]          rdata1;
  logic [xlen-1:0]          rdata2;
  logic [4:0]               waddr;
  logic                     clear;
  logic [xlen-1:0]          mem_rdata;
  logic                     mem_ready;
  logic                     reg_wren;
  logic [4:0]               reg_waddr;
  logic [xlen-1:0]          reg_wdata;
  logic                     stall;
  logic                     stall_q;

  entry_t tbl[$];
  int     errors = 0;
  int     checks = 0;

  rv_execute_top #(.xlen(xlen)) rv_execute_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [xlen-1:0] expv,
                             input logic [xlen-1:0] actv);
    checks++;
    assert (actv === expv) else begin
      errors++;
      $display("ERROR at %0t: %s expected %h actual %h", $time, name, expv, actv);
    end
  endtask

  function automatic void add_entry(input int unit, input logic [3:0] code,
                                    input logic imm_sel, input logic flush,
                                    input logic [4:0] dest, input logic [xlen-1:0] a_val,
                                    input logic [xlen-1:0] b_val,
                                    input logic [xlen-1:0] imm_val,
                                    input logic [xlen-1:0] addr_val,
                                    input logic [xlen-1:0] mem_val, input logic wr,
                                    input logic [xlen-1:0] wr_val);
    entry_t e;
    e = '{unit, code, imm_sel, flush, dest, a_val, b_val, imm_val, addr_val, mem_val,
          wr, wr_val};
    tbl.push_back(e);
  endfunction

  task automatic apply_entry(input entry_t e);
    int lat;
    int cycles;
    int exp_cycles;
    lat = 0;
    cycles = 0;
    if (e.unit == u_load || e.unit == u_store) begin
      lat = $urandom_range(5, 0);
    end
    if (e.flush) begin
      exp_cycles = 0;
    end else if (e.unit == u_div) begin
      exp_cycles = xlen + 1;
    end else begin
      exp_cycles = lat;                 // Zero for units that never wait
    end
    @(posedge clk);
    valid     <= 1'b1;
    op        <= e.code;
    is_alu    <= (e.unit == u_alu);
    is_lui    <= (e.unit == u_lui);
    is_auipc  <= (e.unit == u_auipc);
    is_jump   <= (e.unit == u_jump);
    is_div    <= (e.unit == u_div);
    is_load   <= (e.unit == u_load);
    is_store  <= (e.unit == u_store);
    use_imm   <= e.imm_sel;
    imm       <= e.imm_val;
    address   <= e.addr_val;
    rdata1    <= e.a_val;
    rdata2    <= e.b_val;
    waddr     <= e.dest;
    clear     <= e.flush;
    mem_rdata <= e.mem_val;
    mem_ready <= (lat == 0);
    @(negedge clk);
    check_value("stall_q", 1'b0, stall_q);
    while (stall) begin
      check_value("reg_wren", 1'b0, reg_wren);
      cycles++;
      @(posedge clk);
      mem_ready <= (cycles >= lat);
      valid     <= 1'b0;                // The stage must keep working from its held copy
      op        <= ~e.code;
      address   <= ~e.addr_val;
      rdata1    <= ~e.a_val;
      rdata2    <= ~e.b_val;
      waddr     <= ~e.dest;
      @(negedge clk);
      check_value("stall_q", 1'b1, stall_q);
    end
    check_value("stall cycles", exp_cycles, cycles);
    check_value("reg_wren", e.wr, reg_wren);
    if (e.wr) begin
      check_value("reg_waddr", e.dest, reg_waddr);
      check_value("reg_wdata", e.wr_val, reg_wdata);
    end
  endtask

  initial begin
    void'($urandom(81));
    rst <= 1'b0;
    valid <= 1'b0;
    op <= '0;
    {is_alu, is_lui, is_auipc, is_jump, is_div, is_load, is_store, use_imm} <= '0;
    pc <= 'h1000;
    npc <= 'h1004;                       // Link address of every jump in the table
    imm <= '0;
    address <= '0;
    rdata1 <= '0;
    rdata2 <= '0;
    waddr <= '0;
    clear <= 1'b0;
    mem_rdata <= '0;
    mem_ready <= 1'b1;

    add_entry(u_alu, rv_execute_pkg::alu_add, 0, 0, 1, 'h5, 'h7, 0, 0, 0, 1, 'hc);
    add_entry(u_alu, rv_execute_pkg::alu_add, 1, 0, 2, 'hffff_fff0, 'h9999, 'h20, 0, 0, 1, 'h10);
    add_entry(u_alu, rv_execute_pkg::alu_sub, 0, 0, 3, 'h3, 'h5, 0, 0, 0, 1, 'hffff_fffe);
    add_entry(u_alu, rv_execute_pkg::alu_and, 0, 0, 4, 'hf0f0_f0f0, 'h0ff0_0ff0, 0, 0, 0,
              1, 'h00f0_00f0);
    add_entry(u_alu, rv_execute_pkg::alu_or, 0, 0, 5, 'hf0f0_0000, 'h0f0f, 0, 0, 0,
              1, 'hf0f0_0f0f);
    add_entry(u_alu, rv_execute_pkg::alu_xor, 1, 0, 6, 'h1234_5678, 'h9999, 'hffff_ffff, 0, 0,
              1, 'hedcb_a987);
    add_entry(u_alu, rv_execute_pkg::alu_sll, 0, 0, 7, 'h1, 'd33, 0, 0, 0, 1, 'h2);
    add_entry(u_alu, rv_execute_pkg::alu_sll, 1, 0, 8, 'hff, 'h9999, 'h8, 0, 0, 1, 'hff00);
    add_entry(u_alu, rv_execute_pkg::alu_srl, 0, 0, 9, 'h8000_0000, 'h4, 0, 0, 0, 1, 'h0800_0000);
    add_entry(u_alu, rv_execute_pkg::alu_sra, 0, 0, 10, 'h8000_0000, 'h4, 0, 0, 0, 1, 'hf800_0000);
    add_entry(u_alu, rv_execute_pkg::alu_sra, 1, 0, 11, 'h7000_0000, 'h9999, 'd28, 0, 0, 1, 'h7);
    add_entry(u_alu, rv_execute_pkg::alu_slt, 0, 0, 12, 'hffff_ffff, 'h1, 0, 0, 0, 1, 'h1);
    add_entry(u_alu, rv_execute_pkg::alu_sltu, 0, 0, 13, 'hffff_ffff, 'h1, 0, 0, 0, 1, 'h0);
    add_entry(u_alu, rv_execute_pkg::alu_sltu, 1, 0, 14, 'h1, 'h9999, 'hffff_ffff, 0, 0, 1, 'h1);
    add_entry(u_alu, rv_execute_pkg::alu_add, 0, 0, 0, 'h5, 'h7, 0, 0, 0, 0, 0);

    add_entry(u_lui, 0, 1, 0, 15, 0, 0, 'habcd_e000, 0, 0, 1, 'habcd_e000);
    add_entry(u_auipc, 0, 1, 0, 16, 0, 0, 'h2000, 'h3000, 0, 1, 'h3000);
    add_entry(u_jump, 0, 1, 0, 17, 0, 0, 'h40, 'h1040, 0, 1, 'h1004);
    add_entry(u_jump, 0, 1, 0, 18, 'h4000, 0, 'h10, 'h4010, 0, 1, 'h1004);
    add_entry(u_lui, 0, 1, 0, 0, 0, 0, 'h1234_5000, 0, 0, 0, 0);

    // Divide codes are {2'b00, sign, rem}
    add_entry(u_div, 4'b0010, 0, 0, 19, 'd20, 'hffff_fffd, 0, 0, 0, 1, 'hffff_fffa);
    add_entry(u_div, 4'b0011, 0, 0, 20, 'd20, 'hffff_fffd, 0, 0, 0, 1, 'h2);
    add_entry(u_div, 4'b0011, 0, 0, 21, 'hffff_ffec, 'h3, 0, 0, 0, 1, 'hffff_fffe);
    add_entry(u_div, 4'b0000, 0, 0, 22, 'hffff_fffe, 'h2, 0, 0, 0, 1, 'h7fff_ffff);
    add_entry(u_div, 4'b0001, 0, 0, 23, 'd100, 'd7, 0, 0, 0, 1, 'h2);
    add_entry(u_div, 4'b0010, 0, 0, 24, 'd7, 0, 0, 0, 0, 1, 'hffff_ffff);
    add_entry(u_div, 4'b0011, 0, 0, 25, 'd7, 0, 0, 0, 0, 1, 'h7);
    add_entry(u_div, 4'b0010, 0, 0, 26, 'h8000_0000, 'hffff_ffff, 0, 0, 0, 1, 'h8000_0000);
    add_entry(u_div, 4'b0011, 0, 0, 27, 'h8000_0000, 'hffff_ffff, 0, 0, 0, 1, 'h0);

    // Load and store codes are {store, unsigned, size}
    add_entry(u_load, 4'b0000, 1, 0, 1, 0, 0, 0, 'h2000, 'h8a7f_c301, 1, 'h1);
    add_entry(u_load, 4'b0100, 1, 0, 2, 0, 0, 0, 'h2000, 'h8a7f_c301, 1, 'h1);
    add_entry(u_load, 4'b0000, 1, 0, 3, 0, 0, 0, 'h2001, 'h8a7f_c301, 1, 'hffff_ffc3);
    add_entry(u_load, 4'b0100, 1, 0, 4, 0, 0, 0, 'h2001, 'h8a7f_c301, 1, 'hc3);
    add_entry(u_load, 4'b0000, 1, 0, 5, 0, 0, 0, 'h2002, 'h8a7f_c301, 1, 'h7f);
    add_entry(u_load, 4'b0100, 1, 0, 6, 0, 0, 0, 'h2002, 'h8a7f_c301, 1, 'h7f);
    add_entry(u_load, 4'b0000, 1, 0, 7, 0, 0, 0, 'h2003, 'h8a7f_c301, 1, 'hffff_ff8a);
    add_entry(u_load, 4'b0100, 1, 0, 8, 0, 0, 0, 'h2003, 'h8a7f_c301, 1, 'h8a);
    add_entry(u_load, 4'b0001, 1, 0, 9, 0, 0, 0, 'h2000, 'h8a7f_c301, 1, 'hffff_c301);
    add_entry(u_load, 4'b0101, 1, 0, 10, 0, 0, 0, 'h2000, 'h8a7f_c301, 1, 'hc301);
    add_entry(u_load, 4'b0001, 1, 0, 11, 0, 0, 0, 'h2002, 'h8a7f_c301, 1, 'hffff_8a7f);
    add_entry(u_load, 4'b0101, 1, 0, 12, 0, 0, 0, 'h2002, 'h8a7f_c301, 1, 'h8a7f);
    add_entry(u_load, 4'b0010, 1, 0, 13, 0, 0, 0, 'h2000, 'h8a7f_c301, 1, 'h8a7f_c301);
    add_entry(u_store, 4'b1010, 1, 0, 5, 0, 'h5555, 0, 'h2000, 0, 0, 0);
    add_entry(u_store, 4'b1000, 1, 0, 6, 0, 'h66, 0, 'h2003, 0, 0, 0);

    add_entry(u_alu, rv_execute_pkg::alu_add, 0, 1, 7, 'h5, 'h7, 0, 0, 0, 0, 0);
    add_entry(u_div, 4'b0010, 0, 1, 8, 'd20, 'd4, 0, 0, 0, 0, 0);
    add_entry(u_alu, rv_execute_pkg::alu_add, 0, 0, 9, 'h1, 'h1, 0, 0, 0, 1, 'h2);

    repeat (4) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_value("reg_wren", 1'b0, reg_wren);
    check_value("stall", 1'b0, stall);
    check_value("stall_q", 1'b0, stall_q);
    foreach (tbl[k]) begin
      apply_entry(tbl[k]);
    end
    @(posedge clk);
    valid <= 1'b0;
    @(negedge clk);
    check_value("stall_q", 1'b0, stall_q);
    check_value("reg_wren", 1'b0, reg_wren);
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Every entry gets room for the longest divide plus some slack
  initial begin
    int limit;
    #1;
    limit = (tbl.size() + 2) * (xlen + 10) * 100;
    #(limit);
    $display("Timeout: the table did not finish, the DUT seems stuck in a stall");
    $display("%0d errors in %0d checks", errors, checks);
    $display("Checks failed");
    $finish;
  end

endmodule

/* rv_execute.f */
rtl/rv_execute_pkg.sv
rtl/alu.sv
rtl/divider.sv
rtl/load_align.sv
rtl/execute_stage.sv
rtl/rv_execute_top.sv
testbench/rv_execute_tb.sv

/* Makefile */
# Verilator build and run for the rv_execute testbench

VERILATOR ?= verilator
TOP       ?= rv_execute_tb
FILELIST  ?= rv_execute.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
